/* common/meter_pkg.sv */
package meter_pkg;

    // ----------------------------------------
    // sample and level types

    // two's-complement microphone sample, left channel only
    typedef logic [23:0] sample_t;

    // absolute value of a sample, the most negative sample saturates to all ones
    typedef logic [22:0] magnitude_t;

    // one captured sample, valid is a single-cycle strobe
    typedef struct packed {
        logic    valid;
        sample_t sample;
    } sample_beat_t;

    // ----------------------------------------
    // display types

    // eight hex nibbles, digit 0 shows the least significant one
    typedef logic [31:0] display_word_t;

    typedef logic [3:0] nibble_t;

    // active-high pattern ordered a,b,c,d,e,f,g,dp from the MSB
    typedef logic [7:0] segments_t;

    // ----------------------------------------
    // bar graph constants

    localparam int led_count = 16;

    // lit LEDs are the magnitude shifted right by this amount
    localparam int bar_shift = 19;

endpackage

/* mic/i2s_mic_receiver.sv */
`timescale 1ns/1ps

module i2s_mic_receiver #(
    parameter int clk_mhz = 100
) (
    input  logic                    clk,
    input  logic                    arst_n,
    output logic                    sck,
    output logic                    ws,
    input  logic                    sd,
    output meter_pkg::sample_beat_t beat
);

    // half a bit clock period in clk cycles, about 3 MHz bit clock
    localparam int half_period = clk_mhz / 6;
    localparam int div_w       = $clog2(half_period);
    localparam int sample_bits = $bits(meter_pkg::sample_t);

    typedef enum logic [1:0] {
        st_idle,
        st_left,
        st_skip
    } state_t;

    state_t             state;
    logic [div_w-1:0]   div_cnt;
    logic               half_done;
    logic               sck_rise;
    logic               sck_fall;
    logic [5:0]         bit_cnt;
    logic               frame_end;
    logic               capture;
    logic               last_bit;
    meter_pkg::sample_t shreg;
    logic               valid_q;
    meter_pkg::sample_t sample_q;

    // ----------------------------------------
    // bit clock and slot counting

    assign half_done = div_cnt == div_w'(half_period - 1);
    assign sck_rise  = half_done & ~sck;
    assign sck_fall  = half_done & sck;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end else if (half_done) begin
            div_cnt <= '0;
            sck     <= ~sck;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // slots 0..31 are the left half, word select follows the top bit
    // and so changes on the falling bit clock edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt <= '1;
        end else if (sck_fall) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    assign ws        = bit_cnt[5];
    assign frame_end = sck_fall && bit_cnt == 6'd63;

    // ----------------------------------------
    // capture FSM

    // slot 0 is the one-bit delay after ws falls, data sits in slots 1..24
    assign capture  = state == st_left && sck_rise && bit_cnt != 6'd0;
    assign last_bit = capture && bit_cnt == 6'(sample_bits);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle, st_skip: begin
                    if (frame_end) begin
                        state <= st_left;
                    end
                end
                st_left: begin
                    if (last_bit) begin
                        state <= st_skip;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            shreg <= {shreg[sample_bits-2:0], sd};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= last_bit;
        end
    end

    always_ff @(posedge clk) begin
        if (last_bit) begin
            sample_q <= {shreg[sample_bits-2:0], sd};
        end
    end

    assign beat = '{valid: valid_q, sample: sample_q};

    // the tracker has no back-pressure, so every sample is a one-cycle strobe
    assert property (@(posedge clk) disable iff (!arst_n) beat.valid |=> !beat.valid);

endmodule

/* hdl/scan_strobe_gen.sv */
`timescale 1ns/1ps

module scan_strobe_gen #(
    parameter int scan_div = 100000
) (
    input  logic clk,
    input  logic arst_n,
    output logic tick
);

    localparam int cnt_w = $clog2(scan_div);

    logic [cnt_w-1:0] cnt;

    // free-running divider, tick is high for the cycle after each wrap
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == cnt_w'(scan_div - 1)) begin
            cnt  <= '0;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

/* hdl/level_tracker.sv */
`timescale 1ns/1ps

module level_tracker (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               clear,
    input  logic                               show_peak,
    input  meter_pkg::sample_beat_t            beat,
    output logic [meter_pkg::led_count-1:0]    led,
    output meter_pkg::display_word_t           word
);

    localparam int mag_bits = $bits(meter_pkg::magnitude_t);
    localparam int len_w    = $clog2(meter_pkg::led_count + 1);

    meter_pkg::sample_t            sample_q;
    meter_pkg::sample_t            sample_d;
    meter_pkg::magnitude_t         peak_q;
    meter_pkg::magnitude_t         peak_d;
    meter_pkg::magnitude_t         mag_new;
    meter_pkg::magnitude_t         mag_cur;
    meter_pkg::magnitude_t         shifted;
    logic [len_w-1:0]              bar_len;
    logic [meter_pkg::led_count-1:0] bar_d;
    meter_pkg::display_word_t      word_d;

    function automatic meter_pkg::magnitude_t abs_sat(input meter_pkg::sample_t s);
        meter_pkg::sample_t neg;
        neg = -s;
        if (!s[mag_bits]) begin
            return s[mag_bits-1:0];
        end
        // negating 0x800000 gives itself back, so clamp it
        if (neg[mag_bits]) begin
            return '1;
        end
        return neg[mag_bits-1:0];
    endfunction

    // ----------------------------------------
    // next sample and peak

    assign mag_new  = abs_sat(beat.sample);
    assign sample_d = beat.valid ? beat.sample : sample_q;
    assign mag_cur  = abs_sat(sample_d);

    // a new sample arriving with clear wins over the zero
    always_comb begin
        peak_d = peak_q;
        if (clear) begin
            peak_d = '0;
        end
        if (beat.valid && (clear || mag_new > peak_q)) begin
            peak_d = mag_new;
        end
    end

    // ----------------------------------------
    // bar graph and display word

    assign shifted = mag_cur >> meter_pkg::bar_shift;

    always_comb begin
        if (shifted > mag_bits'(meter_pkg::led_count)) begin
            bar_len = len_w'(meter_pkg::led_count);
        end else begin
            bar_len = shifted[len_w-1:0];
        end
        for (int i = 0; i < meter_pkg::led_count; i++) begin
            bar_d[i] = i < int'(bar_len);
        end
    end

    assign word_d = show_peak ? meter_pkg::display_word_t'(peak_d)
                              : meter_pkg::display_word_t'(signed'(sample_d));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sample_q <= '0;
            peak_q   <= '0;
            led      <= '0;
            word     <= '0;
        end else begin
            sample_q <= sample_d;
            peak_q   <= peak_d;
            led      <= bar_d;
            word     <= word_d;
        end
    end

endmodule

/* display/hex_digit_decoder.sv */
`timescale 1ns/1ps

module hex_digit_decoder (
    input  meter_pkg::nibble_t   value,
    output meter_pkg::segments_t segments
);

    // bits are a,b,c,d,e,f,g,dp with dp kept dark
    always_comb begin
        case (value)
            4'h0: segments = 8'b1111_1100;
            4'h1: segments = 8'b0110_0000;
            4'h2: segments = 8'b1101_1010;
            4'h3: segments = 8'b1111_0010;
            4'h4: segments = 8'b0110_0110;
            4'h5: segments = 8'b1011_0110;
            4'h6: segments = 8'b1011_1110;
            4'h7: segments = 8'b1110_0000;
            4'h8: segments = 8'b1111_1110;
            4'h9: segments = 8'b1111_0110;
            4'ha: segments = 8'b1110_1110;
            // lower case b and d keep them apart from 8 and 0
            4'hb: segments = 8'b0011_1110;
            4'hc: segments = 8'b1001_1100;
            4'hd: segments = 8'b0111_1010;
            4'he: segments = 8'b1001_1110;
            4'hf: segments = 8'b1000_1110;
            default: segments = 8'b0000_0000;
        endcase
    end

endmodule

/* display/digit_scanner.sv */
`timescale 1ns/1ps

module digit_scanner #(
    parameter int w_digit = 8
) (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               tick,
    input  meter_pkg::segments_t [w_digit-1:0] patterns,
    output meter_pkg::segments_t               abcdefgh,
    output logic [w_digit-1:0]                 digit
);

    localparam int idx_w = $clog2(w_digit);

    logic [idx_w-1:0] index;
    logic [idx_w-1:0] index_d;

    // advance one digit per strobe, wrapping after the last one
    always_comb begin
        index_d = index;
        if (tick) begin
            if (index == idx_w'(w_digit - 1)) begin
                index_d = '0;
            end else begin
                index_d = index + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            index <= '0;
            digit <= w_digit'(1);
        end else begin
            index <= index_d;
            digit <= w_digit'(1) << index_d;
        end
    end

    // the pattern is refreshed every cycle so value changes show without
    // waiting for the next strobe
    always_ff @(posedge clk) begin
        abcdefgh <= patterns[index_d];
    end

    // a second low anode would light two digits with one pattern
    assert property (@(posedge clk) disable iff (!arst_n) $onehot(digit));

endmodule

/* hdl/lab_top.sv */
`timescale 1ns/1ps

module lab_top #(
    parameter int clk_mhz  = 100,
    parameter int w_digit  = 8,
    parameter int scan_div = 100000
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            clear,
    input  logic                            show_peak,
    output logic [meter_pkg::led_count-1:0] led,
    output meter_pkg::segments_t            abcdefgh,
    output logic [w_digit-1:0]              digit,
    output logic                            sck,
    output logic                            ws,
    input  logic                            sd
);

    meter_pkg::sample_beat_t            beat;
    meter_pkg::display_word_t           word;
    meter_pkg::segments_t [w_digit-1:0] patterns;
    logic                               tick;

    // ----------------------------------------
    // capture and level tracking

    i2s_mic_receiver #(
        .clk_mhz (clk_mhz)
    ) i_receiver (
        .clk    (clk),
        .arst_n (arst_n),
        .sck    (sck),
        .ws     (ws),
        .sd     (sd),
        .beat   (beat)
    );

    level_tracker i_tracker (
        .clk       (clk),
        .arst_n    (arst_n),
        .clear     (clear),
        .show_peak (show_peak),
        .beat      (beat),
        .led       (led),
        .word      (word)
    );

    // ----------------------------------------
    // display path

    for (genvar i = 0; i < w_digit; i++) begin : gen_digit
        meter_pkg::nibble_t nibble;

        assign nibble = word[4*i +: 4];

        hex_digit_decoder i_decoder (
            .value    (nibble),
            .segments (patterns[i])
        );
    end

    scan_strobe_gen #(
        .scan_div (scan_div)
    ) i_strobe (
        .clk    (clk),
        .arst_n (arst_n),
        .tick   (tick)
    );

    digit_scanner #(
        .w_digit (w_digit)
    ) i_scanner (
        .clk      (clk),
        .arst_n   (arst_n),
        .tick     (tick),
        .patterns (patterns),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

/* hdl/board_top.sv */
`timescale 1ns/1ps

module board_top #(
    parameter int clk_mhz  = 100,
    parameter int w_digit  = 8,
    parameter int scan_div = 100000
) (
    input  logic                            CLK100MHZ,
    input  logic                            arst_n,
    input  logic                            btnc,
    input  logic [15:0]                     sw,
    output logic [meter_pkg::led_count-1:0] led,
    output logic                            ca,
    output logic                            cb,
    output logic                            cc,
    output logic                            cd,
    output logic                            ce,
    output logic                            cf,
    output logic                            cg,
    output logic                            dp,
    output logic [7:0]                      an,
    output logic                            mic_sck,
    output logic                            mic_ws,
    output logic                            mic_lr,
    input  logic                            mic_sd
);

    logic                 clk;
    logic [1:0]           rst_sync;
    logic                 core_arst_n;
    meter_pkg::segments_t abcdefgh;
    logic [w_digit-1:0]   digit;

    assign clk = CLK100MHZ;

    // reset asserts at once and releases two clocks after the pin goes high
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rst_sync <= '0;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign core_arst_n = rst_sync[1];

    // ----------------------------------------
    // core

    lab_top #(
        .clk_mhz  (clk_mhz),
        .w_digit  (w_digit),
        .scan_div (scan_div)
    ) i_lab_top (
        .clk       (clk),
        .arst_n    (core_arst_n),
        .clear     (btnc),
        .show_peak (sw[0]),
        .led       (led),
        .abcdefgh  (abcdefgh),
        .digit     (digit),
        .sck       (mic_sck),
        .ws        (mic_ws),
        .sd        (mic_sd)
    );

    // the display pins are active low
    assign {ca, cb, cc, cd, ce, cf, cg, dp} = ~abcdefgh;
    assign an = ~digit;

    // select the left channel slot on the microphone
    assign mic_lr = 1'b0;

endmodule

/* tb/tb_board_top.sv */
`timescale 1ns/1ps

module tb_board_top;

    localparam int clk_mhz      = 50;
    localparam int w_digit      = 8;
    localparam int scan_div     = 16;
    localparam int frame_cycles = 64 * 2 * (clk_mhz / 6);
    localparam int round_cycles = w_digit * scan_div + scan_div + 4;

    // standard hex glyphs ordered a..g then dp from the MSB with lower case b and d
    localparam meter_pkg::segments_t glyph_table [16] = '{
        8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66, 8'hB6, 8'hBE, 8'hE0,
        8'hFE, 8'hF6, 8'hEE, 8'h3E, 8'h9C, 8'h7A, 8'h9E, 8'h8E
    };

    logic        clk = 1'b0;
    logic        arst_n;
    logic        btnc;
    logic [15:0] sw;
    logic [15:0] led;
    logic        ca, cb, cc, cd, ce, cf, cg, dp;
    logic [7:0]  an;
    logic        mic_sck;
    logic        mic_ws;
    logic        mic_lr;
    logic        mic_sd = 1'b0;

    int                    mismatches = 0;
    int                    failures   = 0;
    meter_pkg::magnitude_t exp_peak   = '0;
    meter_pkg::segments_t  shown [w_digit];

    // microphone model state
    meter_pkg::sample_t tx_queue [$];
    meter_pkg::sample_t tx_word = '0;
    logic               ws_prev = 1'b1;
    int                 slot    = 0;

    always #10 clk = ~clk;

    board_top #(
        .clk_mhz  (clk_mhz),
        .w_digit  (w_digit),
        .scan_div (scan_div)
    ) dut (
        .CLK100MHZ (clk),
        .arst_n    (arst_n),
        .btnc      (btnc),
        .sw        (sw),
        .led       (led),
        .ca        (ca),
        .cb        (cb),
        .cc        (cc),
        .cd        (cd),
        .ce        (ce),
        .cf        (cf),
        .cg        (cg),
        .dp        (dp),
        .an        (an),
        .mic_sck   (mic_sck),
        .mic_ws    (mic_ws),
        .mic_lr    (mic_lr),
        .mic_sd    (mic_sd)
    );

    // ----------------------------------------
    // microphone model

    // data changes on the first falling clk edge after the falling bit clock edge
    // slot 0 is the one-bit delay after ws falls and slots 1..24 carry the sample
    always @(negedge mic_sck) begin
        @(negedge clk);
        if (ws_prev && !mic_ws) begin
            slot = 0;
            if (tx_queue.size() != 0) begin
                tx_word = tx_queue.pop_front();
            end else begin
                tx_word = '0;
            end
        end else begin
            slot = slot + 1;
        end
        ws_prev = mic_ws;
        if (!mic_ws && slot >= 1 && slot <= 24) begin
            mic_sd = tx_word[24 - slot];
        end else begin
            mic_sd = 1'b0;
        end
    end

    // ----------------------------------------
    // expected values

    function automatic meter_pkg::magnitude_t expected_magnitude(input meter_pkg::sample_t s);
        meter_pkg::sample_t neg;
        neg = -s;
        if (s == 24'h800000) begin
            return '1;
        end else if (s[23]) begin
            return neg[22:0];
        end
        return s[22:0];
    endfunction

    function automatic logic [15:0] expected_bar(input meter_pkg::magnitude_t mag);
        int          lit;
        logic [15:0] bar;
        lit = int'(mag >> meter_pkg::bar_shift);
        if (lit > meter_pkg::led_count) begin
            lit = meter_pkg::led_count;
        end
        bar = '0;
        for (int i = 0; i < lit; i++) begin
            bar[i] = 1'b1;
        end
        return bar;
    endfunction

    // ----------------------------------------
    // checks

    task automatic check_segments(input string name, input meter_pkg::segments_t got,
                                  input meter_pkg::segments_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_led(input logic [15:0] exp);
        if (led !== exp) begin
            mismatches++;
            $display("MISMATCH led got 0x%04h expected 0x%04h", led, exp);
        end
    endtask

    task automatic check_pin(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // collects one pattern per digit while checking that the select stays one-hot
    task automatic read_display(output logic complete);
        logic [w_digit-1:0] seen;
        logic [w_digit-1:0] sel;
        int                 cycles;
        seen   = '0;
        cycles = 0;
        while (seen != '1 && cycles < round_cycles) begin
            @(negedge clk);
            cycles++;
            sel = ~an;
            if (!$onehot(sel)) begin
                failures++;
                $display("more or less than one anode is low, an = 0x%02h", an);
            end else begin
                for (int i = 0; i < w_digit; i++) begin
                    if (sel[i]) begin
                        shown[i] = ~{ca, cb, cc, cd, ce, cf, cg, dp};
                        seen[i]  = 1'b1;
                    end
                end
            end
        end
        complete = seen == '1;
        if (!complete) begin
            failures++;
            $display("not every digit was scanned within one round");
        end
    endtask

    task automatic check_word(input meter_pkg::display_word_t exp);
        logic complete;
        read_display(complete);
        if (complete) begin
            for (int i = 0; i < w_digit; i++) begin
                check_segments($sformatf("digit%0d", i), shown[i], glyph_table[exp[4*i +: 4]]);
            end
        end
    endtask

    task automatic check_after_sample(input meter_pkg::sample_t s);
        check_led(expected_bar(expected_magnitude(s)));
        if (sw[0]) begin
            check_word(meter_pkg::display_word_t'(exp_peak));
        end else begin
            check_word({{8{s[23]}}, s});
        end
    endtask

    // ----------------------------------------
    // stimulus

    task automatic send_sample(input meter_pkg::sample_t s);
        int   cycles;
        logic strobe;
        tx_queue.push_back(s);
        cycles = 0;
        while (tx_queue.size() != 0 && cycles < 2 * frame_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (tx_queue.size() != 0) begin
            failures++;
            $display("the microphone model never started a frame");
            tx_queue.delete();
        end
        strobe = 1'b0;
        cycles = 0;
        while (!strobe && cycles < frame_cycles) begin
            @(negedge clk);
            cycles++;
            strobe = dut.i_lab_top.beat.valid;
        end
        if (!strobe) begin
            failures++;
            $display("timed out waiting for the sample strobe");
        end
        if (expected_magnitude(s) > exp_peak) begin
            exp_peak = expected_magnitude(s);
        end
        // one cycle for the tracker and one more for the scanner register
        repeat (2) @(negedge clk);
    endtask

    // ----------------------------------------
    // tests

    // while reset is held the receiver keeps word select high and the bit clock low
    task automatic test_mic_reset_state();
        check_pin("mic_ws", mic_ws, 1'b1);
        check_pin("mic_sck", mic_sck, 1'b0);
    endtask

    task automatic test_after_reset();
        check_led(16'h0000);
        check_word(32'h0000_0000);
        check_pin("mic_lr", mic_lr, 1'b0);
    endtask

    task automatic test_sample_capture();
        meter_pkg::sample_t s;
        sw[0] = 1'b0;
        for (int i = 0; i < 4; i++) begin
            s     = meter_pkg::sample_t'($urandom);
            s[23] = i[0];
            send_sample(s);
            check_after_sample(s);
        end
    endtask

    task automatic test_peak_hold();
        meter_pkg::sample_t s;
        sw[0] = 1'b1;
        for (int i = 0; i < 3; i++) begin
            s     = meter_pkg::sample_t'($urandom);
            s[23] = ~i[0];
            send_sample(s);
            check_after_sample(s);
        end
        send_sample(24'h800000);
        check_after_sample(24'h800000);
        send_sample(24'h000123);
        check_after_sample(24'h000123);
    endtask

    task automatic test_peak_clear();
        btnc = 1'b1;
        @(negedge clk);
        btnc     = 1'b0;
        exp_peak = '0;
        @(negedge clk);
        check_word(32'h0000_0000);
        send_sample(24'hF00000);
        check_after_sample(24'hF00000);
    endtask

    task automatic test_led_bar();
        meter_pkg::sample_t levels [5];
        levels = '{24'h000000, 24'h080000, 24'h3FFFFF, 24'h7FFFFF, 24'h800000};
        sw[0]  = 1'b0;
        for (int i = 0; i < 5; i++) begin
            send_sample(levels[i]);
            check_after_sample(levels[i]);
        end
    endtask

    initial begin
        void'($urandom(44));
        arst_n = 1'b0;
        btnc   = 1'b0;
        sw     = '0;
        repeat (8) @(negedge clk);
        test_mic_reset_state();
        arst_n = 1'b1;
        repeat (4) @(negedge clk);

        test_after_reset();
        test_sample_capture();
        test_peak_hold();
        test_peak_clear();
        test_led_bar();

        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* flist.f */
common/meter_pkg.sv
mic/i2s_mic_receiver.sv
hdl/scan_strobe_gen.sv
hdl/level_tracker.sv
display/hex_digit_decoder.sv
display/digit_scanner.sv
hdl/lab_top.sv
hdl/board_top.sv
tb/tb_board_top.sv

/* Makefile */
# Verilator build and run for the microphone level meter

TOOL  := verilator
FLAGS := --binary --timing --assert -Wno-fatal -j 0
TOP   := tb_board_top
FLIST := flist.f
BUILD := obj_dir
LOG   := sim.log
PASS  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)

# the run fails unless the log holds the pass message
run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
